// ==== rtl/mem_event_pkg.sv ====
// ----------------------------------------------------------------------
// memory event definitions seen on the cache side of the core
// lane limits and the per-cycle event count types used by the
// strobe classifier and the counter block
// ----------------------------------------------------------------------

`default_nettype none

package mem_event_pkg;

    // largest data-cache lane count the monitor supports
    localparam int MAX_LANES = 8;

    // lane count used when the top level is left at its default
    localparam int DEFAULT_NUM_LANES = 4;

    // width that holds 0..MAX_LANES
    localparam int LANE_COUNT_BITS = $clog2(MAX_LANES + 1);

    // number of data-cache lanes firing in one cycle
    typedef logic [LANE_COUNT_BITS-1:0] lane_count_t;

    // signed change in outstanding reads for one cycle
    // spanning -MAX_LANES..+MAX_LANES
    typedef logic signed [LANE_COUNT_BITS:0] pending_delta_t;

endpackage

`default_nettype wire

// ==== rtl/perf_pkg.sv ====
// ----------------------------------------------------------------------
// performance counter definitions
// counter width and type, report interval type and its default
// ----------------------------------------------------------------------

`default_nettype none

package perf_pkg;

    // width of every running counter and pending-read total
    localparam int PERF_CTR_BITS = 48;

    // running counter wide enough to never wrap in practice
    typedef logic [PERF_CTR_BITS-1:0] perf_ctr_t;

    // report interval counter
    typedef logic [31:0] interval_t;

    // cycles between periodic reports when nothing else is set
    localparam interval_t DEFAULT_REPORT_INTERVAL = 32'd10000;

endpackage

`default_nettype wire

// ==== rtl/mem_event_classifier.sv ====
// ----------------------------------------------------------------------
// memory event classifier
// forms fetch and data-cache fire conditions, splits requests into
// loads and stores, and produces registered per-cycle counts and
// pending-read changes for the counter block
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module mem_event_classifier #(
    parameter int NUM_LANES = mem_event_pkg::DEFAULT_NUM_LANES
) (
    input  logic                               clk,
    input  logic                               reset,

    input  logic                               icache_req_valid,
    input  logic                               icache_req_ready,
    input  logic                               icache_rsp_valid,
    input  logic                               icache_rsp_ready,

    input  logic [NUM_LANES-1:0]               dcache_req_valid,
    input  logic [NUM_LANES-1:0]               dcache_req_ready,
    input  logic [NUM_LANES-1:0]               dcache_req_rw,
    input  logic [NUM_LANES-1:0]               dcache_rsp_valid,
    input  logic [NUM_LANES-1:0]               dcache_rsp_ready,

    output logic                               ifetch_fire,
    output mem_event_pkg::pending_delta_t      ifetch_delta,
    output mem_event_pkg::lane_count_t         load_count,
    output mem_event_pkg::lane_count_t         store_count,
    output mem_event_pkg::pending_delta_t      load_delta
);

    // number of set bits in a lane vector
    function automatic mem_event_pkg::lane_count_t pop_count(input logic [NUM_LANES-1:0] bits);
        mem_event_pkg::lane_count_t cnt;
        cnt = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            cnt = cnt + mem_event_pkg::lane_count_t'(bits[i]);
        end
        return cnt;
    endfunction

    logic                 icache_req_fire;
    logic                 icache_rsp_fire;
    logic [NUM_LANES-1:0] load_fire;
    logic [NUM_LANES-1:0] store_fire;
    logic [NUM_LANES-1:0] rsp_fire;
    logic [NUM_LANES-1:0] load_fire_r;
    logic [NUM_LANES-1:0] store_fire_r;

    mem_event_pkg::lane_count_t load_cnt;
    mem_event_pkg::lane_count_t store_cnt;
    mem_event_pkg::lane_count_t rsp_cnt;

    // a transfer counts only when valid and ready meet
    assign icache_req_fire = icache_req_valid && icache_req_ready;
    assign icache_rsp_fire = icache_rsp_valid && icache_rsp_ready;

    assign load_fire  = dcache_req_valid & dcache_req_ready & ~dcache_req_rw;
    assign store_fire = dcache_req_valid & dcache_req_ready & dcache_req_rw;
    assign rsp_fire   = dcache_rsp_valid & dcache_rsp_ready;

    // request fires count from the delayed copy, responses do not
    assign load_cnt  = pop_count(load_fire_r);
    assign store_cnt = pop_count(store_fire_r);
    assign rsp_cnt   = pop_count(rsp_fire);

    always_ff @(posedge clk) begin
        if (reset) begin
            load_fire_r  <= '0;
            store_fire_r <= '0;
            ifetch_fire  <= 1'b0;
            ifetch_delta <= '0;
            load_count   <= '0;
            store_count  <= '0;
            load_delta   <= '0;
        end else begin
            load_fire_r  <= load_fire;
            store_fire_r <= store_fire;
            ifetch_fire  <= icache_req_fire;
            ifetch_delta <= mem_event_pkg::pending_delta_t'(icache_req_fire)
                          - mem_event_pkg::pending_delta_t'(icache_rsp_fire);
            load_count   <= load_cnt;
            store_count  <= store_cnt;
            load_delta   <= mem_event_pkg::pending_delta_t'(load_cnt)
                          - mem_event_pkg::pending_delta_t'(rsp_cnt);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/perf_accumulator.sv ====
// ----------------------------------------------------------------------
// performance accumulator
// pending-read totals for fetches and loads, and the five running
// counters: fetches, loads, stores, fetch and load latency
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module perf_accumulator (
    input  logic                           clk,
    input  logic                           reset,

    input  logic                           ifetch_fire,
    input  mem_event_pkg::pending_delta_t  ifetch_delta,
    input  mem_event_pkg::pending_delta_t  load_delta,
    input  mem_event_pkg::lane_count_t     load_count,
    input  mem_event_pkg::lane_count_t     store_count,

    output perf_pkg::perf_ctr_t            ifetches,
    output perf_pkg::perf_ctr_t            loads,
    output perf_pkg::perf_ctr_t            stores,
    output perf_pkg::perf_ctr_t            ifetch_latency,
    output perf_pkg::perf_ctr_t            load_latency
);

    // deltas widened to counter size with sign kept
    logic signed [perf_pkg::PERF_CTR_BITS-1:0] ifetch_delta_ext;
    logic signed [perf_pkg::PERF_CTR_BITS-1:0] load_delta_ext;

    // reads issued but not yet answered
    perf_pkg::perf_ctr_t ifetch_pending;
    perf_pkg::perf_ctr_t load_pending;

    assign ifetch_delta_ext = ifetch_delta;
    assign load_delta_ext   = load_delta;

    // two's complement add handles the negative deltas
    always_ff @(posedge clk) begin
        if (reset) begin
            ifetch_pending <= '0;
            load_pending   <= '0;
        end else begin
            ifetch_pending <= ifetch_pending + perf_pkg::perf_ctr_t'(ifetch_delta_ext);
            load_pending   <= load_pending + perf_pkg::perf_ctr_t'(load_delta_ext);
        end
    end

    // event counters
    always_ff @(posedge clk) begin
        if (reset) begin
            ifetches <= '0;
            loads    <= '0;
            stores   <= '0;
        end else begin
            ifetches <= ifetches + perf_pkg::perf_ctr_t'(ifetch_fire);
            loads    <= loads + perf_pkg::perf_ctr_t'(load_count);
            stores   <= stores + perf_pkg::perf_ctr_t'(store_count);
        end
    end

    // each outstanding read adds one cycle of latency,
    // using the total as it stood last cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ifetch_latency <= '0;
            load_latency   <= '0;
        end else begin
            ifetch_latency <= ifetch_latency + ifetch_pending;
            load_latency   <= load_latency + load_pending;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/perf_report_latch.sv ====
// ----------------------------------------------------------------------
// performance report latch
// triggers on a falling busy level or when the report interval
// wraps, then snapshots the five counters for one valid cycle
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module perf_report_latch #(
    parameter perf_pkg::interval_t REPORT_INTERVAL = perf_pkg::DEFAULT_REPORT_INTERVAL
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 busy,

    input  perf_pkg::perf_ctr_t  ifetches,
    input  perf_pkg::perf_ctr_t  loads,
    input  perf_pkg::perf_ctr_t  stores,
    input  perf_pkg::perf_ctr_t  ifetch_latency,
    input  perf_pkg::perf_ctr_t  load_latency,

    output logic                 report_valid,
    output perf_pkg::perf_ctr_t  snap_ifetches,
    output perf_pkg::perf_ctr_t  snap_loads,
    output perf_pkg::perf_ctr_t  snap_stores,
    output perf_pkg::perf_ctr_t  snap_ifetch_latency,
    output perf_pkg::perf_ctr_t  snap_load_latency
);

    logic                busy_prev;
    logic                busy_negedge;
    logic                trigger;
    perf_pkg::interval_t report_counter;

    // counter runs 0..REPORT_INTERVAL, so the period is one longer
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_prev      <= 1'b0;
            report_counter <= '0;
        end else begin
            busy_prev <= busy;
            if (report_counter == REPORT_INTERVAL) begin
                report_counter <= '0;
            end else begin
                report_counter <= report_counter + 32'd1;
            end
        end
    end

    // core went idle
    assign busy_negedge = busy_prev && !busy;
    assign trigger      = busy_negedge || (report_counter == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            report_valid        <= 1'b0;
            snap_ifetches       <= '0;
            snap_loads          <= '0;
            snap_stores         <= '0;
            snap_ifetch_latency <= '0;
            snap_load_latency   <= '0;
        end else begin
            report_valid <= trigger;
            if (trigger) begin
                snap_ifetches       <= ifetches;
                snap_loads          <= loads;
                snap_stores         <= stores;
                snap_ifetch_latency <= ifetch_latency;
                snap_load_latency   <= load_latency;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mem_perf_monitor.sv ====
// ----------------------------------------------------------------------
// memory traffic performance monitor, top level
// classifier -> accumulator -> report latch, observing the
// instruction and data cache strobes of one core
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module mem_perf_monitor #(
    parameter int                  NUM_LANES       = mem_event_pkg::DEFAULT_NUM_LANES,
    parameter perf_pkg::interval_t REPORT_INTERVAL = perf_pkg::DEFAULT_REPORT_INTERVAL
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 busy,

    input  logic                 icache_req_valid,
    input  logic                 icache_req_ready,
    input  logic                 icache_rsp_valid,
    input  logic                 icache_rsp_ready,

    input  logic [NUM_LANES-1:0] dcache_req_valid,
    input  logic [NUM_LANES-1:0] dcache_req_ready,
    input  logic [NUM_LANES-1:0] dcache_req_rw,
    input  logic [NUM_LANES-1:0] dcache_rsp_valid,
    input  logic [NUM_LANES-1:0] dcache_rsp_ready,

    output logic                 report_valid,
    output perf_pkg::perf_ctr_t  snap_ifetches,
    output perf_pkg::perf_ctr_t  snap_loads,
    output perf_pkg::perf_ctr_t  snap_stores,
    output perf_pkg::perf_ctr_t  snap_ifetch_latency,
    output perf_pkg::perf_ctr_t  snap_load_latency
);

    // per-cycle events
    logic                          ifetch_fire;
    mem_event_pkg::pending_delta_t ifetch_delta;
    mem_event_pkg::lane_count_t    load_count;
    mem_event_pkg::lane_count_t    store_count;
    mem_event_pkg::pending_delta_t load_delta;

    // running counters
    perf_pkg::perf_ctr_t ifetches;
    perf_pkg::perf_ctr_t loads;
    perf_pkg::perf_ctr_t stores;
    perf_pkg::perf_ctr_t ifetch_latency;
    perf_pkg::perf_ctr_t load_latency;

    mem_event_classifier #(
        .NUM_LANES (NUM_LANES)
    ) classifier (
        .clk              (clk),
        .reset            (reset),
        .icache_req_valid (icache_req_valid),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp_ready (icache_rsp_ready),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req_ready (dcache_req_ready),
        .dcache_req_rw    (dcache_req_rw),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp_ready (dcache_rsp_ready),
        .ifetch_fire      (ifetch_fire),
        .ifetch_delta     (ifetch_delta),
        .load_count       (load_count),
        .store_count      (store_count),
        .load_delta       (load_delta)
    );

    perf_accumulator accumulator (
        .clk            (clk),
        .reset          (reset),
        .ifetch_fire    (ifetch_fire),
        .ifetch_delta   (ifetch_delta),
        .load_delta     (load_delta),
        .load_count     (load_count),
        .store_count    (store_count),
        .ifetches       (ifetches),
        .loads          (loads),
        .stores         (stores),
        .ifetch_latency (ifetch_latency),
        .load_latency   (load_latency)
    );

    perf_report_latch #(
        .REPORT_INTERVAL (REPORT_INTERVAL)
    ) report_latch (
        .clk                 (clk),
        .reset               (reset),
        .busy                (busy),
        .ifetches            (ifetches),
        .loads               (loads),
        .stores              (stores),
        .ifetch_latency      (ifetch_latency),
        .load_latency        (load_latency),
        .report_valid        (report_valid),
        .snap_ifetches       (snap_ifetches),
        .snap_loads          (snap_loads),
        .snap_stores         (snap_stores),
        .snap_ifetch_latency (snap_ifetch_latency),
        .snap_load_latency   (snap_load_latency)
    );

endmodule

`default_nettype wire

// ==== tests/tb_mem_perf_monitor.sv ====
// ----------------------------------------------------------------------
// testbench for the memory traffic performance monitor
// table of fetch, load and store rows with stalls and response delays,
// a running model of the expected counters, report monitor and watchdog
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_mem_perf_monitor #(
    parameter int NUM_LANES       = 4,
    parameter int REPORT_INTERVAL = 200
);

    localparam real         CLK_PERIOD      = 20.0;
    localparam int          RESET_CYCLES    = 16;
    localparam int          PERIOD          = REPORT_INTERVAL + 1;
    localparam int          NUM_ROWS        = 12;
    localparam int          WATCHDOG_CYCLES = NUM_ROWS * 40 + 2000;
    localparam logic [31:0] SEED            = 32'h9389_ebea;

    localparam logic [1:0] KIND_FETCH = 2'd0;
    localparam logic [1:0] KIND_LOAD  = 2'd1;
    localparam logic [1:0] KIND_STORE = 2'd2;

    // kind, lanes, response delay, stall cycles and busy drop of one operation
    typedef struct packed {
        logic [1:0]           kind;
        logic [NUM_LANES-1:0] mask;
        logic [3:0]           delay;
        logic [3:0]           stall;
        logic                 drop;
    } row_t;

    logic                 clk;
    logic                 reset;
    logic                 busy;
    logic                 icache_req_valid;
    logic                 icache_req_ready;
    logic                 icache_rsp_valid;
    logic                 icache_rsp_ready;
    logic [NUM_LANES-1:0] dcache_req_valid;
    logic [NUM_LANES-1:0] dcache_req_ready;
    logic [NUM_LANES-1:0] dcache_req_rw;
    logic [NUM_LANES-1:0] dcache_rsp_valid;
    logic [NUM_LANES-1:0] dcache_rsp_ready;

    logic                report_valid;
    perf_pkg::perf_ctr_t snap_ifetches;
    perf_pkg::perf_ctr_t snap_loads;
    perf_pkg::perf_ctr_t snap_stores;
    perf_pkg::perf_ctr_t snap_ifetch_latency;
    perf_pkg::perf_ctr_t snap_load_latency;

    row_t        rows [NUM_ROWS];
    longint      cycle_count;
    longint      first_report;
    logic        monitor_on;
    logic        fall_window;
    logic [63:0] m_ifetches;
    logic [63:0] m_loads;
    logic [63:0] m_stores;
    logic [63:0] m_ifetch_latency;
    logic [63:0] m_load_latency;

    mem_perf_monitor #(
        .NUM_LANES       (NUM_LANES),
        .REPORT_INTERVAL (REPORT_INTERVAL)
    ) DUT (
        .clk                 (clk),
        .reset               (reset),
        .busy                (busy),
        .icache_req_valid    (icache_req_valid),
        .icache_req_ready    (icache_req_ready),
        .icache_rsp_valid    (icache_rsp_valid),
        .icache_rsp_ready    (icache_rsp_ready),
        .dcache_req_valid    (dcache_req_valid),
        .dcache_req_ready    (dcache_req_ready),
        .dcache_req_rw       (dcache_req_rw),
        .dcache_rsp_valid    (dcache_rsp_valid),
        .dcache_rsp_ready    (dcache_rsp_ready),
        .report_valid        (report_valid),
        .snap_ifetches       (snap_ifetches),
        .snap_loads          (snap_loads),
        .snap_stores         (snap_stores),
        .snap_ifetch_latency (snap_ifetch_latency),
        .snap_load_latency   (snap_load_latency)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2.0) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic abort_run(input string why);
        $display("%s (time %0t)", why, $time);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
        if (got !== expected) begin
            $display("Error at time %0t: %s is %0d, expected %0d", $time, name, got, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_snapshots(input logic [63:0] exp_ifetches, input logic [63:0] exp_loads,
                                   input logic [63:0] exp_stores, input logic [63:0] exp_if_lat,
                                   input logic [63:0] exp_ld_lat);
        check("snap_ifetches", 64'(snap_ifetches), exp_ifetches);
        check("snap_loads", 64'(snap_loads), exp_loads);
        check("snap_stores", 64'(snap_stores), exp_stores);
        check("snap_ifetch_latency", 64'(snap_ifetch_latency), exp_if_lat);
        check("snap_load_latency", 64'(snap_load_latency), exp_ld_lat);
    endtask

    // every pulse must come from the interval or from a falling busy level
    always @(negedge clk) begin
        if (monitor_on) begin
            if (report_valid && ((cycle_count - first_report) % PERIOD != 0) && !fall_window) begin
                abort_run("report_valid pulsed with no interval wrap and no busy fall");
            end
            if (!report_valid && ((cycle_count - first_report) % PERIOD == 0)) begin
                abort_run("periodic report_valid pulse is missing");
            end
        end
    end

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_report(output longint at);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!report_valid) begin
            waited++;
            if (waited > PERIOD + 4) begin
                abort_run("no report_valid pulse within one report interval");
            end
            @(negedge clk);
        end
        at = cycle_count;
    endtask

    task automatic drive_request(input row_t r, input logic accept);
        if (r.kind == KIND_FETCH) begin
            icache_req_valid <= 1'b1;
            icache_req_ready <= accept;
        end else begin
            dcache_req_valid <= r.mask;
            // idle lanes show ready without valid
            dcache_req_ready <= accept ? '1 : ~r.mask;
            dcache_req_rw    <= (r.kind == KIND_STORE) ? r.mask : '0;
        end
    endtask

    task automatic clear_request();
        icache_req_valid <= 1'b0;
        icache_req_ready <= 1'b0;
        dcache_req_valid <= '0;
        dcache_req_ready <= '0;
        dcache_req_rw    <= '0;
    endtask

    task automatic drive_response(input row_t r);
        if (r.kind == KIND_FETCH) begin
            icache_rsp_valid <= 1'b1;
            icache_rsp_ready <= 1'b1;
        end else begin
            dcache_rsp_valid <= r.mask;
            dcache_rsp_ready <= '1;
        end
    endtask

    task automatic clear_response();
        icache_rsp_valid <= 1'b0;
        icache_rsp_ready <= 1'b0;
        dcache_rsp_valid <= '0;
        dcache_rsp_ready <= '0;
    endtask

    // stall cycles and the accepting cycle followed by the response N cycles later
    task automatic apply_row(input row_t r);
        for (int i = 0; i <= int'(r.stall); i++) begin
            @(posedge clk);
            drive_request(r, i == int'(r.stall));
        end
        if (r.kind == KIND_STORE) begin
            @(posedge clk);
            clear_request();
        end else begin
            for (int i = 1; i <= int'(r.delay); i++) begin
                @(posedge clk);
                if (i == 1) clear_request();
                if (i == int'(r.delay)) drive_response(r);
            end
            @(posedge clk);
            clear_response();
        end
    endtask

    task automatic update_model(input row_t r);
        logic [63:0] lanes;
        lanes = 64'($countones(r.mask));
        case (r.kind)
            KIND_FETCH: begin
                m_ifetches       = m_ifetches + 64'd1;
                m_ifetch_latency = m_ifetch_latency + 64'(r.delay);
            end
            KIND_LOAD: begin
                m_loads = m_loads + lanes;
                // load fires are seen one cycle late, so one cycle less per lane
                m_load_latency = m_load_latency + lanes * 64'(r.delay - 4'd1);
            end
            default: m_stores = m_stores + lanes;
        endcase
    endtask

    // after busy falls the next report carries the model totals
    task automatic drop_busy_and_check();
        logic seen;
        seen = 1'b0;
        @(posedge clk);
        busy        <= 1'b0;
        fall_window = 1'b1;
        repeat (2) begin
            @(negedge clk);
            if (report_valid) seen = 1'b1;
        end
        if (!seen) abort_run("no report_valid pulse after busy fell");
        check_snapshots(m_ifetches, m_loads, m_stores, m_ifetch_latency, m_load_latency);
        @(posedge clk);
        fall_window = 1'b0;
        idle(2 + int'($urandom % 4));
        @(posedge clk);
        busy <= 1'b1;
        idle(4);
    endtask

    task automatic fill_table();
        rows[0]  = '{KIND_FETCH, 4'b0000, 4'd2, 4'd0, 1'b0};
        rows[1]  = '{KIND_FETCH, 4'b0000, 4'd7, 4'd3, 1'b1};
        rows[2]  = '{KIND_LOAD,  4'b0001, 4'd2, 4'd0, 1'b0};
        rows[3]  = '{KIND_LOAD,  4'b1011, 4'd4, 4'd0, 1'b0};
        // same as the row above with stalls added
        rows[4]  = '{KIND_LOAD,  4'b1011, 4'd4, 4'd2, 1'b1};
        rows[5]  = '{KIND_STORE, 4'b0110, 4'd0, 4'd0, 1'b0};
        rows[6]  = '{KIND_STORE, 4'b1111, 4'd0, 4'd1, 1'b1};
        rows[7]  = '{KIND_FETCH, 4'b0000, 4'd9, 4'd1, 1'b0};
        rows[8]  = '{KIND_LOAD,  4'b1111, 4'd9, 4'd3, 1'b0};
        rows[9]  = '{KIND_STORE, 4'b1000, 4'd0, 4'd2, 1'b0};
        rows[10] = '{KIND_LOAD,  4'b0100, 4'd3, 4'd0, 1'b0};
        rows[11] = '{KIND_FETCH, 4'b0000, 4'd3, 4'd0, 1'b1};
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("timeout, the test did not finish within the expected number of cycles");
    end

    initial begin
        longint last;
        longint at;
        void'($urandom(SEED));
        reset            = 1'b1;
        busy             = 1'b0;
        icache_req_valid = 1'b0;
        icache_req_ready = 1'b0;
        icache_rsp_valid = 1'b0;
        icache_rsp_ready = 1'b0;
        dcache_req_valid = '0;
        dcache_req_ready = '0;
        dcache_req_rw    = '0;
        dcache_rsp_valid = '0;
        dcache_rsp_ready = '0;
        cycle_count      = 0;
        first_report     = 0;
        monitor_on       = 1'b0;
        fall_window      = 1'b0;
        m_ifetches       = '0;
        m_loads          = '0;
        m_stores         = '0;
        m_ifetch_latency = '0;
        m_load_latency   = '0;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        busy  <= 1'b1;

        // only periodic reports while busy stays high with no traffic
        wait_report(first_report);
        check_snapshots(0, 0, 0, 0, 0);
        last = first_report;
        for (int n = 0; n < 3; n++) begin
            wait_report(at);
            check("report period", 64'(at - last), 64'(PERIOD));
            check_snapshots(0, 0, 0, 0, 0);
            last = at;
        end
        @(posedge clk);
        monitor_on = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(rows[r]);
            update_model(rows[r]);
            idle(4 + int'($urandom % 9));
            if (rows[r].drop) drop_busy_and_check();
        end
        idle(8);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/mem_event_pkg.sv
rtl/perf_pkg.sv
rtl/mem_event_classifier.sv
rtl/perf_accumulator.sv
rtl/perf_report_latch.sv
rtl/mem_perf_monitor.sv
tests/tb_mem_perf_monitor.sv

// ==== Makefile ====
# Verilator flow for the memory traffic performance monitor
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mem_perf_monitor
LOG       ?= sim.log
FLAGS     ?= --timing -Wno-fatal

RTL_TOP   := mem_perf_monitor
OBJ_DIR   := obj_dir
FILELIST  := compile.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only -Wall $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)_sim
	-./$(OBJ_DIR)/$(TOP)_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^Simulation passed$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
